// File: his_pkg.sv
package his_pkg;

    // default histogram geometry
    // the top level passes these down as module parameters

    // time bins per pixel histogram
    // kept a power of two so the bin field packs cleanly into the address
    localparam int NB_DEF = 8;

    // pixels that share one histogram bank
    localparam int PIXEL_NUM_DEF = 4;

    // photon events per pixel in one acquisition
    localparam int DATA_NUM_DEF = 2;

    // acquisitions that make up one series
    localparam int ACQ_NUM_DEF = 3;

    // derived widths

    // bin index inside one pixel histogram
    localparam int BIN_W = $clog2(NB_DEF);

    // pixel index, at least one bit
    localparam int PIX_W = (PIXEL_NUM_DEF > 1) ? $clog2(PIXEL_NUM_DEF) : 1;

    // bank address is {pixel, bin}
    localparam int ADDR_W = BIN_W + PIX_W;

    // worst case for one bin is every event of a pixel over the whole series
    // landing in that bin
    // clog2 plus one bit always holds that value, even at a power of two
    localparam int COUNT_W = $clog2(DATA_NUM_DEF * ACQ_NUM_DEF) + 1;

endpackage

// File: his_sequencer.sv
`timescale 1ns/1ps

module his_sequencer #(
    parameter int PIXEL_NUM = his_pkg::PIXEL_NUM_DEF,
    parameter int DATA_NUM  = his_pkg::DATA_NUM_DEF,
    parameter int ACQ_NUM   = his_pkg::ACQ_NUM_DEF
) (
    input  logic                      clk,
    input  logic                      combin_res,
    input  logic                      wr_en,
    input  logic [his_pkg::BIN_W-1:0]  bin,
    output logic                      addr_valid,
    output logic [his_pkg::ADDR_W-1:0] addr,
    output logic                      series_done
);

    import his_pkg::*;

    // counter widths, never below one bit
    localparam int EVT_W = $clog2(DATA_NUM + 1);
    localparam int ACQ_W = $clog2(ACQ_NUM + 1);

    // events seen for the current pixel
    logic [EVT_W-1:0] evt_cnt;
    // pixel currently being filled
    logic [PIX_W-1:0] pix_cnt;
    // acquisition inside the series
    logic [ACQ_W-1:0] acq_cnt;

    logic last_evt;
    logic last_pix;
    logic last_acq;

    // wrap points of the three nested counters
    assign last_evt = (evt_cnt == EVT_W'(DATA_NUM - 1));
    assign last_pix = (pix_cnt == PIX_W'(PIXEL_NUM - 1));
    assign last_acq = (acq_cnt == ACQ_W'(ACQ_NUM - 1));

    // nested counting, events inside pixels inside acquisitions
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            evt_cnt     <= '0;
            pix_cnt     <= '0;
            acq_cnt     <= '0;
            addr_valid  <= 1'b0;
            series_done <= 1'b0;
        end else begin
            // one address per photon strobe
            addr_valid  <= wr_en;
            // final event of the final acquisition closes the series
            series_done <= wr_en & last_evt & last_pix & last_acq;
            if (wr_en) begin
                if (!last_evt) begin
                    evt_cnt <= evt_cnt + EVT_W'(1);
                end else begin
                    evt_cnt <= '0;
                    if (!last_pix) begin
                        pix_cnt <= pix_cnt + PIX_W'(1);
                    end else begin
                        pix_cnt <= '0;
                        // all pixels done, step the acquisition
                        if (!last_acq) begin
                            acq_cnt <= acq_cnt + ACQ_W'(1);
                        end else begin
                            acq_cnt <= '0;
                        end
                    end
                end
            end
        end
    end

    // address payload
    // pixel in the upper bits, bin in the lower bits
    always_ff @(posedge clk) begin
        if (wr_en) begin
            addr <= {pix_cnt, bin};
        end
    end

endmodule

// File: his_bank_accumulator.sv
`timescale 1ns/1ps

module his_bank_accumulator #(
    parameter int NB        = his_pkg::NB_DEF,
    parameter int PIXEL_NUM = his_pkg::PIXEL_NUM_DEF
) (
    input  logic                       clk,
    input  logic                       combin_res,
    input  logic                       addr_valid,
    input  logic [his_pkg::ADDR_W-1:0]  addr,
    input  logic                       series_done,
    input  logic                       rd_en,
    input  logic [his_pkg::ADDR_W-1:0]  rd_addr,
    output logic [his_pkg::COUNT_W-1:0] bin_count,
    output logic                       count_valid,
    output logic                       his_num,
    output logic [his_pkg::COUNT_W-1:0] rd_data
);

    import his_pkg::*;

    // bins held by one bank
    localparam int DEPTH = NB * PIXEL_NUM;

    // two banks of bin counts
    // a count is only meaningful while its valid bit is set
    logic [COUNT_W-1:0] mem [2][DEPTH];

    // per-bin valid bits
    // clearing a bin is just dropping its bit
    logic [DEPTH-1:0] vld [2];

    // bank under readout is always the one not being written
    logic rd_bank;

    // read-modify-write path for the incoming event
    logic [COUNT_W-1:0] cur_count;
    logic               cur_vld;
    logic [COUNT_W-1:0] new_count;

    assign rd_bank = ~his_num;

    assign cur_count = mem[his_num][addr];
    assign cur_vld   = vld[his_num][addr];

    // first hit of a bin starts at one, stale data is ignored
    assign new_count = cur_vld ? (cur_count + COUNT_W'(1)) : COUNT_W'(1);

    // control state
    // bank select, valid bits and the count strobe
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            his_num     <= 1'b0;
            count_valid <= 1'b0;
            vld[0]      <= '0;
            vld[1]      <= '0;
        end else begin
            count_valid <= addr_valid;
            // the closing event still lands in the old bank
            if (addr_valid && series_done) begin
                his_num <= ~his_num;
            end
            // mark bin as live in the write bank
            if (addr_valid) begin
                vld[his_num][addr] <= 1'b1;
            end
            // clear on read in the finished bank
            if (rd_en) begin
                vld[rd_bank][rd_addr] <= 1'b0;
            end
        end
    end

    // bank storage, write side
    // whole update in one cycle so back to back hits on one bin chain correctly
    always_ff @(posedge clk) begin
        if (addr_valid) begin
            mem[his_num][addr] <= new_count;
        end
    end

    // new count reported one cycle after the address
    always_ff @(posedge clk) begin
        if (addr_valid) begin
            bin_count <= new_count;
        end
    end

    // read side
    // bins never written in this series read as zero
    always_ff @(posedge clk) begin
        if (rd_en) begin
            if (vld[rd_bank][rd_addr]) begin
                rd_data <= mem[rd_bank][rd_addr];
            end else begin
                rd_data <= '0;
            end
        end
    end

endmodule

// File: his_peak_readout.sv
`timescale 1ns/1ps

module his_peak_readout #(
    parameter int NB        = his_pkg::NB_DEF,
    parameter int PIXEL_NUM = his_pkg::PIXEL_NUM_DEF
) (
    input  logic                       clk,
    input  logic                       combin_res,
    input  logic                       his_num,
    input  logic [his_pkg::COUNT_W-1:0] rd_data,
    output logic                       rd_en,
    output logic [his_pkg::ADDR_W-1:0]  rd_addr,
    output logic                       peak_valid,
    output logic [his_pkg::PIX_W-1:0]   peak_pixel,
    output logic [his_pkg::BIN_W-1:0]   peak_bin,
    output logic [his_pkg::COUNT_W-1:0] peak_count,
    output logic                       readout_busy,
    output logic                       readout_overrun
);

    import his_pkg::*;

    // final address of a full sweep
    localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(NB * PIXEL_NUM - 1);

    // bank swap detect
    logic his_num_d;
    logic his_edge;

    // read issue state
    logic rd_act;

    // read data pipeline, rd_data matches vld_addr
    logic              rd_vld;
    logic [ADDR_W-1:0] vld_addr;
    logic              first_bin;
    logic              last_bin;

    // running maximum for the pixel under readout
    logic [COUNT_W-1:0] max_count;
    logic [BIN_W-1:0]   max_bin;
    logic [COUNT_W-1:0] run_count;
    logic [BIN_W-1:0]   run_bin;

    assign his_edge = his_num ^ his_num_d;

    // no read on the swap cycle
    // the old sweep address would hit the freshly finished bank
    assign rd_en = rd_act & ~his_edge;

    assign first_bin = (vld_addr[BIN_W-1:0] == '0);
    assign last_bin  = (vld_addr[BIN_W-1:0] == BIN_W'(NB - 1));

    // strict compare so the lowest bin keeps a tie
    always_comb begin
        if (first_bin || (rd_data > max_count)) begin
            run_count = rd_data;
            run_bin   = vld_addr[BIN_W-1:0];
        end else begin
            run_count = max_count;
            run_bin   = max_bin;
        end
    end

    // sweep control
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            his_num_d       <= 1'b0;
            rd_act          <= 1'b0;
            rd_addr         <= '0;
            rd_vld          <= 1'b0;
            peak_valid      <= 1'b0;
            readout_busy    <= 1'b0;
            readout_overrun <= 1'b0;
        end else begin
            his_num_d  <= his_num;
            rd_vld     <= rd_en;
            // one result per pixel, dropped if a restart cuts in
            peak_valid <= rd_vld & last_bin & ~his_edge;
            if (his_edge) begin
                // new bank finished, start or restart the sweep
                rd_act       <= 1'b1;
                rd_addr      <= '0;
                readout_busy <= 1'b1;
                // swap arrived before the previous sweep was done
                if (readout_busy) begin
                    readout_overrun <= 1'b1;
                end
            end else begin
                if (rd_act) begin
                    if (rd_addr == LAST_ADDR) begin
                        rd_act <= 1'b0;
                    end else begin
                        rd_addr <= rd_addr + ADDR_W'(1);
                    end
                end
                // busy drops with the last pixel result
                if (rd_vld && (vld_addr == LAST_ADDR)) begin
                    readout_busy <= 1'b0;
                end
            end
        end
    end

    // address follows the read by one cycle
    always_ff @(posedge clk) begin
        vld_addr <= rd_addr;
    end

    // max tracker and result payload
    always_ff @(posedge clk) begin
        if (rd_vld) begin
            max_count <= run_count;
            max_bin   <= run_bin;
        end
        if (rd_vld && last_bin) begin
            peak_count <= run_count;
            peak_bin   <= run_bin;
            peak_pixel <= vld_addr[ADDR_W-1:BIN_W];
        end
    end

endmodule

// File: his_builder_top.sv
`timescale 1ns/1ps

module his_builder_top #(
    parameter int NB        = his_pkg::NB_DEF,
    parameter int PIXEL_NUM = his_pkg::PIXEL_NUM_DEF,
    parameter int DATA_NUM  = his_pkg::DATA_NUM_DEF,
    parameter int ACQ_NUM   = his_pkg::ACQ_NUM_DEF
) (
    input  logic                       clk,
    input  logic                       combin_res,
    input  logic                       wr_en,
    input  logic [his_pkg::BIN_W-1:0]   bin,
    output logic [his_pkg::COUNT_W-1:0] bin_count,
    output logic                       count_valid,
    output logic                       his_num,
    output logic                       peak_valid,
    output logic [his_pkg::PIX_W-1:0]   peak_pixel,
    output logic [his_pkg::BIN_W-1:0]   peak_bin,
    output logic [his_pkg::COUNT_W-1:0] peak_count,
    output logic                       readout_busy,
    output logic                       readout_overrun
);

    import his_pkg::*;

    // sequencer to accumulator
    logic              addr_valid;
    logic [ADDR_W-1:0] addr;
    logic              series_done;

    // readout port of the finished bank
    logic               rd_en;
    logic [ADDR_W-1:0]  rd_addr;
    logic [COUNT_W-1:0] rd_data;

    // decode, event to bank address
    his_sequencer #(
        .PIXEL_NUM (PIXEL_NUM),
        .DATA_NUM  (DATA_NUM),
        .ACQ_NUM   (ACQ_NUM)
    ) u_seq (
        .clk         (clk),
        .combin_res  (combin_res),
        .wr_en       (wr_en),
        .bin         (bin),
        .addr_valid  (addr_valid),
        .addr        (addr),
        .series_done (series_done)
    );

    // two histogram banks
    his_bank_accumulator #(
        .NB        (NB),
        .PIXEL_NUM (PIXEL_NUM)
    ) u_acc (
        .clk         (clk),
        .combin_res  (combin_res),
        .addr_valid  (addr_valid),
        .addr        (addr),
        .series_done (series_done),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .bin_count   (bin_count),
        .count_valid (count_valid),
        .his_num     (his_num),
        .rd_data     (rd_data)
    );

    // sweep of the finished bank
    his_peak_readout #(
        .NB        (NB),
        .PIXEL_NUM (PIXEL_NUM)
    ) u_rdo (
        .clk             (clk),
        .combin_res      (combin_res),
        .his_num         (his_num),
        .rd_data         (rd_data),
        .rd_en           (rd_en),
        .rd_addr         (rd_addr),
        .peak_valid      (peak_valid),
        .peak_pixel      (peak_pixel),
        .peak_bin        (peak_bin),
        .peak_count      (peak_count),
        .readout_busy    (readout_busy),
        .readout_overrun (readout_overrun)
    );

endmodule

// File: his_builder_sva.sv
`timescale 1ns/1ps

module his_builder_sva (
    input logic clk,
    input logic combin_res,
    input logic addr_valid,
    input logic series_done,
    input logic count_valid,
    input logic his_num,
    input logic peak_valid,
    input logic readout_busy,
    input logic readout_overrun
);

    // count strobe trails the address by one cycle
    assert property (@(posedge clk) disable iff (!combin_res)
        count_valid == $past(addr_valid)) else $error("count_valid not one cycle after addr_valid");

    // bank swap only right after the closing event
    assert property (@(posedge clk) disable iff (!combin_res)
        $changed(his_num) |-> $past(series_done && addr_valid))
        else $error("his_num changed without series_done");

    // results only inside a sweep or on its last cycle
    assert property (@(posedge clk) disable iff (!combin_res)
        peak_valid |-> (readout_busy || $past(readout_busy)))
        else $error("peak_valid outside a sweep");

    // sticky overrun
    assert property (@(posedge clk) disable iff (!combin_res)
        readout_overrun |=> readout_overrun) else $error("readout_overrun fell");

endmodule

bind his_builder_top his_builder_sva u_sva (
    .clk             (clk),
    .combin_res      (combin_res),
    .addr_valid      (addr_valid),
    .series_done     (series_done),
    .count_valid     (count_valid),
    .his_num         (his_num),
    .peak_valid      (peak_valid),
    .readout_busy    (readout_busy),
    .readout_overrun (readout_overrun)
);

// File: his_builder_tb.sv
`timescale 1ns/1ps

module his_builder_tb;

    import his_pkg::*;

    logic               clk;
    logic               combin_res;
    logic               wr_en;
    logic [BIN_W-1:0]   bin;
    logic [COUNT_W-1:0] bin_count;
    logic               count_valid;
    logic               his_num;
    logic               peak_valid;
    logic [PIX_W-1:0]   peak_pixel;
    logic [BIN_W-1:0]   peak_bin;
    logic [COUNT_W-1:0] peak_count;
    logic               readout_busy;
    logic               readout_overrun;

    // reference histograms, one per bank
    int model [2][PIXEL_NUM_DEF][NB_DEF];
    int wr_bank;
    int seed;
    int evt_since_swap;
    logic his_num_seen;
    logic peak_check_en;

    // expected values still in flight
    int count_q[$];
    int peak_pix_q[$];
    int peak_bin_q[$];
    int peak_cnt_q[$];

    his_builder_top dut0 (
        .clk             (clk),
        .combin_res      (combin_res),
        .wr_en           (wr_en),
        .bin             (bin),
        .bin_count       (bin_count),
        .count_valid     (count_valid),
        .his_num         (his_num),
        .peak_valid      (peak_valid),
        .peak_pixel      (peak_pixel),
        .peak_bin        (peak_bin),
        .peak_count      (peak_count),
        .readout_busy    (readout_busy),
        .readout_overrun (readout_overrun)
    );

    always #4 clk = ~clk;

    task automatic stop_on_mismatch(input string sig, input int exp, input int got);
        $display("error at %0t ns: %s expected %0d got %0d", $time, sig, exp, got);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic stop_on_problem(input string what);
        $display("at %0t ns: %s", $time, what);
        $display("Test failed");
        $fatal(1);
    endtask

    // one strobe, then idle cycles
    task automatic send_event(input int pix, input int b, input int gap);
        @(posedge clk);
        wr_en <= 1'b1;
        bin   <= BIN_W'(b);
        model[wr_bank][pix][b] = model[wr_bank][pix][b] + 1;
        count_q.push_back(model[wr_bank][pix][b]);
        repeat (gap) begin
            @(posedge clk);
            wr_en <= 1'b0;
        end
    endtask

    // peak per pixel from the model, lowest bin keeps a tie
    task automatic close_series(input logic keep_peaks);
        int best;
        int best_bin;
        for (int p = 0; p < PIXEL_NUM_DEF; p++) begin
            best     = 0;
            best_bin = 0;
            for (int b = 0; b < NB_DEF; b++) begin
                if (model[wr_bank][p][b] > best) begin
                    best     = model[wr_bank][p][b];
                    best_bin = b;
                end
                // bank is read out and cleared
                model[wr_bank][p][b] = 0;
            end
            if (keep_peaks) begin
                peak_pix_q.push_back(p);
                peak_bin_q.push_back(best_bin);
                peak_cnt_q.push_back(best);
            end
        end
        wr_bank = 1 - wr_bank;
    endtask

    // full series in sequencer order
    // tie puts pixel 1 evenly on bins 2 and 5
    task automatic send_series(input int gap, input logic tie, input logic keep_peaks);
        logic [31:0] rnd;
        int b;
        for (int a = 0; a < ACQ_NUM_DEF; a++) begin
            for (int p = 0; p < PIXEL_NUM_DEF; p++) begin
                for (int e = 0; e < DATA_NUM_DEF; e++) begin
                    rnd = $random(seed);
                    b   = int'(rnd[BIN_W-1:0]);
                    if (tie && p == 1) begin
                        b = (e == 0) ? 2 : 5;
                    end
                    send_event(p, b, gap);
                end
            end
        end
        // a burst leaves the strobe high after its last event
        if (gap == 0) begin
            @(posedge clk);
            wr_en <= 1'b0;
        end
        close_series(keep_peaks);
    endtask

    task automatic wait_readout_idle();
        int i;
        for (i = 0; i < 300; i++) begin
            @(posedge clk);
            if (peak_pix_q.size() == 0 && !readout_busy && count_q.size() == 0) begin
                break;
            end
        end
        if (i == 300) begin
            stop_on_problem("readout did not deliver all pixel peaks in time");
        end
    endtask

    task automatic wait_overrun();
        int i;
        for (i = 0; i < 200; i++) begin
            @(posedge clk);
            if (readout_overrun && count_q.size() == 0) begin
                break;
            end
        end
        if (i == 200) begin
            stop_on_problem("readout_overrun never set after a burst mid-sweep");
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (combin_res) begin
            if (count_valid) begin
                evt_since_swap = evt_since_swap + 1;
                if (count_q.size() == 0) begin
                    stop_on_problem("count_valid with no event outstanding");
                end
                assert (int'(bin_count) == count_q[0])
                    else stop_on_mismatch("bin_count", count_q[0], int'(bin_count));
                void'(count_q.pop_front());
            end
            // swap only after a whole series
            if (his_num != his_num_seen) begin
                assert (evt_since_swap == DATA_NUM_DEF * PIXEL_NUM_DEF * ACQ_NUM_DEF)
                    else stop_on_mismatch("events before his_num toggle",
                                          DATA_NUM_DEF * PIXEL_NUM_DEF * ACQ_NUM_DEF,
                                          evt_since_swap);
                evt_since_swap = 0;
                his_num_seen   = his_num;
            end
            if (peak_valid && peak_check_en) begin
                if (peak_pix_q.size() == 0) begin
                    stop_on_problem("peak_valid with no pixel result expected");
                end
                assert (int'(peak_pixel) == peak_pix_q[0])
                    else stop_on_mismatch("peak_pixel", peak_pix_q[0], int'(peak_pixel));
                assert (int'(peak_bin) == peak_bin_q[0])
                    else stop_on_mismatch("peak_bin", peak_bin_q[0], int'(peak_bin));
                assert (int'(peak_count) == peak_cnt_q[0])
                    else stop_on_mismatch("peak_count", peak_cnt_q[0], int'(peak_count));
                // busy falls together with the last pixel result
                assert (int'(readout_busy) == ((peak_pix_q[0] == PIXEL_NUM_DEF - 1) ? 0 : 1))
                    else stop_on_mismatch("readout_busy",
                                          (peak_pix_q[0] == PIXEL_NUM_DEF - 1) ? 0 : 1,
                                          int'(readout_busy));
                void'(peak_pix_q.pop_front());
                void'(peak_bin_q.pop_front());
                void'(peak_cnt_q.pop_front());
            end
        end
    end

    initial begin
        clk            = 1'b0;
        combin_res     = 1'b0;
        wr_en          = 1'b0;
        bin            = '0;
        seed           = 32'h2656;
        wr_bank        = 0;
        evt_since_swap = 0;
        his_num_seen   = 1'b0;
        peak_check_en  = 1'b1;
        for (int k = 0; k < 2; k++) begin
            for (int p = 0; p < PIXEL_NUM_DEF; p++) begin
                for (int b = 0; b < NB_DEF; b++) begin
                    model[k][p][b] = 0;
                end
            end
        end
        repeat (8) @(posedge clk);
        combin_res <= 1'b1;
        repeat (2) @(posedge clk);

        // bank 0 with a tied pixel, back to back events
        send_series(0, 1'b1, 1'b1);
        wait_readout_idle();
        // bank 1, spaced events
        send_series(2, 1'b0, 1'b1);
        wait_readout_idle();
        // bank 0 again, bins must restart at one
        send_series(1, 1'b1, 1'b1);
        wait_readout_idle();
        assert (readout_overrun == 1'b0)
            else stop_on_mismatch("readout_overrun", 0, int'(readout_overrun));

        // spaced series then a burst right into its sweep
        peak_check_en = 1'b0;
        send_series(2, 1'b0, 1'b0);
        send_series(0, 1'b0, 1'b0);
        wait_overrun();
        repeat (4) @(posedge clk);

        if (count_q.size() == 0 && peak_pix_q.size() == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            $display("expected results were left undelivered");
            $display("Test failed");
            $fatal(1);
        end
    end

endmodule

// File: project.f
his_pkg.sv
his_sequencer.sv
his_bank_accumulator.sv
his_peak_readout.sv
his_builder_top.sv
his_builder_sva.sv
his_builder_tb.sv

// File: run_sim.sh
#!/bin/bash
# build and run the histogram builder testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f project.f --top-module his_builder_tb \
    -o Vhis_builder_tb || { echo "build failed"; exit 1; }
out="$(./obj_dir/Vhis_builder_tb 2>&1)"
echo "$out"
echo "$out" | grep -q "Test completed successfully" && exit 0 || exit 1
